// File: common/bus_pkg.sv
package bus_pkg;

    // one data word as seen on every bus link
    typedef logic [31:0] word_t;

    // byte address, bits [1:0] pick the lane and are ignored for word access
    typedef logic [31:0] addr_t;

    typedef logic [3:0] byte_en_t;  // one strobe per byte lane

    // request driven toward memory
    // fields stay stable while ren or wen is up and busy is high
    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    // answer flowing back to the requester
    // busy low marks the single completing cycle, rdata valid then for reads
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

endpackage

// File: common/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// RAM depth in words
`define MEM_WORDS 1024

// cycles a request is held before the RAM completes, 0 completes at once
`define MEM_WAIT 2

// icache line count, one word per line, power of two
`define ICACHE_LINES 16

`endif

// File: dv/tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_subsystem;

    localparam int WIDX = $clog2(`MEM_WORDS);

    logic              CLK = 1'b0;
    logic              nRST;
    bus_pkg::bus_req_t imem_req;
    bus_pkg::bus_rsp_t imem_rsp;
    bus_pkg::bus_req_t dmem_req;
    bus_pkg::bus_rsp_t dmem_rsp;

    bus_pkg::word_t model [`MEM_WORDS];  // expected RAM contents

    int err_count;
    int pass_tests;
    int fail_tests;

    mem_subsystem_top mem_subsystem_top_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp)
    );

    initial begin
        forever #2 CLK = ~CLK;
    end

    function automatic bus_pkg::addr_t word_addr(input int w);
        return bus_pkg::addr_t'(w) << 2;
    endfunction

    // only the enabled byte lanes take the new data
    function automatic bus_pkg::word_t merge_lanes(input bus_pkg::word_t old_w,
                                                   input bus_pkg::word_t new_w,
                                                   input bus_pkg::byte_en_t be);
        bus_pkg::word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    task automatic check_word(input string name, input bus_pkg::word_t exp,
                              input bus_pkg::word_t act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    // holds the driven request until busy drops, then releases it on the next edge
    task automatic wait_for_port(input bit data_port, input bus_pkg::addr_t addr,
                                 output bus_pkg::word_t rdata, output logic first_busy,
                                 output bit ok);
        int   n;
        logic busy;
        n = 0;
        ok = 1'b0;
        rdata = '0;
        first_busy = 1'b1;
        while (!ok && n < 100) begin
            @(negedge CLK);
            busy = data_port ? dmem_rsp.busy : imem_rsp.busy;
            if (n == 0) first_busy = busy;
            if (!busy) begin
                ok = 1'b1;
                rdata = data_port ? dmem_rsp.rdata : imem_rsp.rdata;
            end
            n++;
        end
        if (!ok) begin
            $display("timeout: %s access to %h never completed",
                     data_port ? "dmem" : "imem", addr);
            err_count++;
        end
        @(posedge CLK);
        if (data_port) dmem_req <= '0;
        else imem_req <= '0;
    endtask

    task automatic dmem_write(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
                              input bus_pkg::byte_en_t be);
        bus_pkg::bus_req_t r;
        bus_pkg::word_t    unused_rd;
        logic              fb;
        bit                ok;
        r = '0;
        r.wen = 1'b1;
        r.addr = addr;
        r.wdata = data;
        r.byte_en = be;
        @(posedge CLK);
        dmem_req <= r;
        wait_for_port(1'b1, addr, unused_rd, fb, ok);
        if (ok) model[addr[WIDX+1:2]] = merge_lanes(model[addr[WIDX+1:2]], data, be);
    endtask

    task automatic dmem_read(input bus_pkg::addr_t addr, output bus_pkg::word_t rdata);
        bus_pkg::bus_req_t r;
        logic              fb;
        bit                ok;
        r = '0;
        r.ren = 1'b1;
        r.addr = addr;
        r.byte_en = '1;
        @(posedge CLK);
        dmem_req <= r;
        wait_for_port(1'b1, addr, rdata, fb, ok);
    endtask

    task automatic imem_read(input bus_pkg::addr_t addr, output bus_pkg::word_t rdata,
                             output logic first_busy);
        bus_pkg::bus_req_t r;
        bit                ok;
        r = '0;
        r.ren = 1'b1;
        r.addr = addr;
        r.byte_en = '1;
        @(posedge CLK);
        imem_req <= r;
        wait_for_port(1'b0, addr, rdata, first_busy, ok);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: passed", name);
            pass_tests++;
        end else begin
            $display("%s: failed with %0d errors", name, err_count - errs_before);
            fail_tests++;
        end
    endtask

    task automatic reset_state_test();
        int e0;
        e0 = err_count;
        repeat (4) begin
            @(negedge CLK);
            check_busy("imem_rsp.busy", 1'b1, imem_rsp.busy);
            check_busy("dmem_rsp.busy", 1'b1, dmem_rsp.busy);
        end
        @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) begin  // idle after reset, still no completion
            @(negedge CLK);
            check_busy("imem_rsp.busy", 1'b1, imem_rsp.busy);
            check_busy("dmem_rsp.busy", 1'b1, dmem_rsp.busy);
        end
        end_test("reset state", e0);
    endtask

    task automatic data_round_trip_test();
        int             e0;
        bus_pkg::addr_t a;
        bus_pkg::addr_t addrs [8];
        bus_pkg::word_t got;
        e0 = err_count;
        for (int i = 0; i < 16; i++) begin
            // first half full words, then random strobes
            if (i < 8) begin
                a = word_addr(int'($urandom % `MEM_WORDS));
                addrs[i] = a;
                dmem_write(a, $urandom, 4'hf);
            end else begin
                a = addrs[i-8];  // strobes land on words that already hold data
                dmem_write(a, $urandom, bus_pkg::byte_en_t'($urandom));
            end
            dmem_read(a, got);
            check_word("dmem_rsp.rdata", model[a[WIDX+1:2]], got);
        end
        end_test("data round trip", e0);
    endtask

    task automatic imem_miss_hit_test();
        int             e0;
        bus_pkg::addr_t a;
        bus_pkg::word_t got;
        logic           fb;
        e0 = err_count;
        for (int w = 'h100; w < 'h104; w++) dmem_write(word_addr(w), $urandom, 4'hf);
        for (int w = 'h100; w < 'h104; w++) begin
            a = word_addr(w);
            imem_read(a, got, fb);
            check_busy("imem_rsp.busy", 1'b1, fb);  // miss waits on the RAM
            check_word("imem_rsp.rdata", model[a[WIDX+1:2]], got);
            imem_read(a, got, fb);
            check_busy("imem_rsp.busy", 1'b0, fb);
            check_word("imem_rsp.rdata", model[a[WIDX+1:2]], got);
        end
        end_test("instruction miss then hit", e0);
    endtask

    task automatic conflict_test();
        int             e0;
        bus_pkg::addr_t a;
        bus_pkg::addr_t b;
        bus_pkg::word_t got;
        logic           fb;
        e0 = err_count;
        a = word_addr('h200);
        b = word_addr('h200 + `ICACHE_LINES);  // same line, other tag
        dmem_write(a, $urandom, 4'hf);
        dmem_write(b, $urandom, 4'hf);
        repeat (3) begin
            imem_read(a, got, fb);
            check_word("imem_rsp.rdata", model[a[WIDX+1:2]], got);
            imem_read(b, got, fb);
            check_word("imem_rsp.rdata", model[b[WIDX+1:2]], got);
        end
        end_test("conflict eviction", e0);
    endtask

    task automatic stale_line_test();
        int             e0;
        bus_pkg::addr_t a;
        bus_pkg::addr_t b;
        bus_pkg::word_t v1;
        bus_pkg::word_t got;
        logic           fb;
        e0 = err_count;
        a = word_addr('h300);
        b = word_addr('h300 + `ICACHE_LINES);
        v1 = $urandom;
        dmem_write(a, v1, 4'hf);
        imem_read(a, got, fb);
        imem_read(a, got, fb);
        check_word("imem_rsp.rdata", v1, got);
        dmem_write(a, ~v1, 4'hf);
        imem_read(a, got, fb);
        check_word("imem_rsp.rdata", v1, got);  // no coherence, old copy
        imem_read(b, got, fb);
        check_word("imem_rsp.rdata", model[b[WIDX+1:2]], got);
        imem_read(a, got, fb);
        check_word("imem_rsp.rdata", ~v1, got);
        end_test("stale instruction line", e0);
    endtask

    task automatic simultaneous_test();
        int                e0;
        int                n;
        int                d_cyc;
        int                i_cyc;
        bus_pkg::bus_req_t ir;
        bus_pkg::bus_req_t dr;
        bus_pkg::word_t    d_got;
        bus_pkg::word_t    i_got;
        e0 = err_count;
        dmem_write(word_addr('h380), $urandom, 4'hf);
        dmem_write(word_addr('h390), $urandom, 4'hf);
        ir = '0;
        ir.ren = 1'b1;
        ir.addr = word_addr('h380);
        ir.byte_en = '1;
        dr = ir;
        dr.addr = word_addr('h390);
        n = 0;
        d_cyc = 0;
        i_cyc = 0;
        d_got = '0;
        i_got = '0;
        @(posedge CLK);
        imem_req <= ir;
        dmem_req <= dr;
        while ((d_cyc == 0 || i_cyc == 0) && n < 100) begin
            @(negedge CLK);
            n++;
            if (d_cyc == 0) check_busy("imem_rsp.busy", 1'b1, imem_rsp.busy);
            if (d_cyc == 0 && !dmem_rsp.busy) begin
                d_cyc = n;
                d_got = dmem_rsp.rdata;
            end else if (i_cyc == 0 && !imem_rsp.busy) begin
                i_cyc = n;
                i_got = imem_rsp.rdata;
            end
            @(posedge CLK);
            if (d_cyc != 0) dmem_req <= '0;
            if (i_cyc != 0) imem_req <= '0;
        end
        if (d_cyc == 0 || i_cyc == 0) begin
            $display("timeout: simultaneous imem and dmem requests did not both complete");
            err_count++;
        end else if (i_cyc <= d_cyc) begin
            $display("imem finished in cycle %0d, not after dmem in cycle %0d", i_cyc, d_cyc);
            err_count++;
        end
        imem_req <= '0;
        dmem_req <= '0;
        check_word("dmem_rsp.rdata", model['h390], d_got);
        check_word("imem_rsp.rdata", model['h380], i_got);
        end_test("simultaneous requests", e0);
    endtask

    initial begin
        nRST = 1'b0;
        imem_req = '0;
        dmem_req = '0;
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        for (int i = 0; i < `MEM_WORDS; i++) model[i] = '0;
        void'($urandom(32'h8afe_ae45));

        reset_state_test();
        data_round_trip_test();
        imem_miss_hit_test();
        conflict_test();
        stale_line_test();
        simultaneous_test();

        $display("tests passed %0d failed %0d, check errors %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: icache/icache.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module icache (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t cpu_req,
    output bus_pkg::bus_rsp_t cpu_rsp,
    output bus_pkg::bus_req_t mem_req,
    input  bus_pkg::bus_rsp_t mem_rsp
);
    localparam int INDEX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W   = 30 - INDEX_W;  // word address bits above the index

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    typedef enum logic {LOOKUP, FILL} state_t;

    state_t state, next_state;

    tag_t                     tag_arr  [`ICACHE_LINES];
    bus_pkg::word_t           data_arr [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid;

    index_t index;
    tag_t   tag;
    logic   hit;
    logic   fill_done;

    // read-only cache, wen, wdata and byte_en from the cpu side are ignored
    // so data writes never reach a cached line until it is replaced
    assign index     = cpu_req.addr[INDEX_W+1:2];
    assign tag       = cpu_req.addr[31:INDEX_W+2];
    assign hit       = valid[index] && (tag_arr[index] == tag);
    assign fill_done = (state == FILL) && !mem_rsp.busy;

    always_comb begin
        mem_req       = '0;
        cpu_rsp.busy  = 1'b1;
        cpu_rsp.rdata = '0;

        case (state)
            LOOKUP: begin
                if (cpu_req.ren && hit) begin
                    cpu_rsp.busy  = 1'b0;  // hit answers in the request cycle
                    cpu_rsp.rdata = data_arr[index];
                end
            end
            FILL: begin
                mem_req.ren     = 1'b1;
                mem_req.addr    = {cpu_req.addr[31:2], 2'b00};
                mem_req.byte_en = '1;
                // fill data goes straight back to the cpu
                cpu_rsp.busy    = mem_rsp.busy;
                cpu_rsp.rdata   = mem_rsp.rdata;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            LOOKUP: begin
                if (cpu_req.ren && !hit) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                if (!mem_rsp.busy) begin
                    next_state = LOOKUP;
                end
            end
            default: next_state = LOOKUP;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= LOOKUP;
            valid <= '0;
        end else begin
            state <= next_state;
            if (fill_done) begin
                valid[index] <= 1'b1;
            end
        end
    end

    // line payload, installed on the completing edge
    always_ff @(posedge CLK) begin
        if (fill_done) begin
            tag_arr[index]  <= tag;
            data_arr[index] <= mem_rsp.rdata;
        end
    end

endmodule

// File: list.f
+incdir+common
common/bus_pkg.sv
src/memory_arbiter.sv
icache/icache.sv
src/wait_state_ram.sv
src/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator.
# Exits non-zero if the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_mem_subsystem

verilator --binary --timing -f list.f --top-module "$TOP" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// File: src/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t imem_req,
    output bus_pkg::bus_rsp_t imem_rsp,
    input  bus_pkg::bus_req_t dmem_req,
    output bus_pkg::bus_rsp_t dmem_rsp
);
    bus_pkg::bus_req_t ic_mem_req;  // icache fill toward the arbiter
    bus_pkg::bus_rsp_t ic_mem_rsp;
    bus_pkg::bus_req_t ram_req;
    bus_pkg::bus_rsp_t ram_rsp;

    icache icache_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .cpu_req (imem_req),
        .cpu_rsp (imem_rsp),
        .mem_req (ic_mem_req),
        .mem_rsp (ic_mem_rsp)
    );

    // data side skips the cache
    memory_arbiter memory_arbiter_inst (
        .CLK        (CLK),
        .nRST       (nRST),
        .icache_req (ic_mem_req),
        .icache_rsp (ic_mem_rsp),
        .dcache_req (dmem_req),
        .dcache_rsp (dmem_rsp),
        .mem_req    (ram_req),
        .mem_rsp    (ram_rsp)
    );

    wait_state_ram wait_state_ram_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (ram_req),
        .rsp  (ram_rsp)
    );

endmodule

// File: src/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t icache_req,
    output bus_pkg::bus_rsp_t icache_rsp,
    input  bus_pkg::bus_req_t dcache_req,
    output bus_pkg::bus_rsp_t dcache_rsp,
    output bus_pkg::bus_req_t mem_req,
    input  bus_pkg::bus_rsp_t mem_rsp
);
    typedef enum logic [1:0] {IDLE, I_OWNED, D_OWNED} state_t;

    state_t state, next_state;

    logic i_active;
    logic d_active;
    logic grant_i;
    logic grant_d;

    assign i_active = icache_req.ren || icache_req.wen;
    assign d_active = dcache_req.ren || dcache_req.wen;

    // data wins in idle, owner keeps the port until memory finishes
    always_comb begin
        grant_i = 1'b0;
        grant_d = 1'b0;
        case (state)
            IDLE: begin
                if (d_active) begin
                    grant_d = 1'b1;
                end else if (i_active) begin
                    grant_i = 1'b1;
                end
            end
            I_OWNED: grant_i = 1'b1;
            D_OWNED: grant_d = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        mem_req          = '0;
        icache_rsp.busy  = 1'b1;  // loser just sees back-pressure
        icache_rsp.rdata = '0;
        dcache_rsp.busy  = 1'b1;
        dcache_rsp.rdata = '0;

        if (grant_d) begin
            mem_req    = dcache_req;
            dcache_rsp = mem_rsp;
        end else if (grant_i) begin
            mem_req    = icache_req;
            icache_rsp = mem_rsp;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // lock only if the transfer does not finish this cycle
                if (grant_d && mem_rsp.busy) begin
                    next_state = D_OWNED;
                end else if (grant_i && mem_rsp.busy) begin
                    next_state = I_OWNED;
                end
            end
            I_OWNED, D_OWNED: begin
                if (!mem_rsp.busy) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: src/wait_state_ram.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module wait_state_ram (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp
);
    localparam int ADDR_W = $clog2(`MEM_WORDS);
    localparam int CNT_W  = ($clog2(`MEM_WAIT + 1) > 0) ? $clog2(`MEM_WAIT + 1) : 1;

    bus_pkg::word_t mem [`MEM_WORDS];

    logic [ADDR_W-1:0] word_idx;
    logic [CNT_W-1:0]  wait_cnt;
    logic              active;
    logic              done;

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx = req.addr[ADDR_W+1:2];  // wraps at the array depth
    assign active   = req.ren || req.wen;
    assign done     = active && (wait_cnt == CNT_W'(`MEM_WAIT));

    assign rsp.busy  = !done;
    assign rsp.rdata = mem[word_idx];

    // counts held cycles, cleared on completion or when idle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!active || done) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (done && req.wen) begin
            for (int i = 0; i < 4; i++) begin
                if (req.byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule
